// ==== source/dram_bridge_defs.svh ====
`ifndef DRAM_BRIDGE_DEFS_SVH
`define DRAM_BRIDGE_DEFS_SVH

// --------------------
// datapath widths
`define DB_WORD_W      32
`define DB_PADDR_W     28
`define DB_EPA_W       16

// outstanding transactions
`define DB_TAGS        8
`define DB_TAG_W       3

// --------------------
// network coordinates and cache tile geometry
`define DB_X_W         4
`define DB_Y_W         4
`define DB_TILES_X_LOG 2
`define DB_BLOCK_LOG   3
`define DB_Y_NORTH     0
`define DB_Y_SOUTH     9

// nonzero selects the xor hash on the tile x index
`define DB_HASH_XOR    1

`endif

// ==== source/dram_bridge_pkg.sv ====
`include "dram_bridge_defs.svh"

package dram_bridge_pkg;

  // --------------------
  // vectors with a meaning of their own

  // one data word
  typedef logic [`DB_WORD_W-1:0]  word_t;

  // processor byte address, also the width of the word offset
  typedef logic [`DB_PADDR_W-1:0] paddr_t;

  // word address inside a dram cache tile
  typedef logic [`DB_EPA_W-1:0]   epa_t;

  // transaction id carried by each packet
  typedef logic [`DB_TAG_W-1:0]   tag_t;

  // network coordinates
  typedef logic [`DB_X_W-1:0]     x_cord_t;
  typedef logic [`DB_Y_W-1:0]     y_cord_t;

  // --------------------
  // message encodings

  // processor side request and response type
  typedef enum logic {MSG_RD, MSG_WR} mem_msg_e;

  // network side operation
  typedef enum logic {OP_LOAD, OP_STORE} net_op_e;

endpackage

// ==== source/dram_bridge_if.sv ====
`timescale 1ns/100ps

// request handoff from the intake register to the issue stage
interface fwd_req_if;
  import dram_bridge_pkg::*;

  logic     valid;
  logic     take;
  mem_msg_e msg_type;
  paddr_t   addr;
  word_t    data;

  modport src (output valid, output msg_type, output addr, output data, input take);
  modport dst (input valid, input msg_type, input addr, input data, output take);
endinterface

// tag allocation and header write into the reorder buffer
interface tag_alloc_if;
  import dram_bridge_pkg::*;

  logic     avail;
  tag_t     tag;
  logic     take;
  mem_msg_e msg_type;
  paddr_t   addr;

  modport owner (output avail, output tag, input take, input msg_type, input addr);
  modport user (input avail, input tag, output take, output msg_type, output addr);
endinterface

// ==== source/fwd_intake.sv ====
`timescale 1ns/100ps

module fwd_intake
  (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      fwd_v_i,
    output logic                      fwd_ready_o,
    input  dram_bridge_pkg::mem_msg_e fwd_msg_type_i,
    input  dram_bridge_pkg::paddr_t   fwd_addr_i,
    input  dram_bridge_pkg::word_t    fwd_data_i,
    fwd_req_if.src                    req_o
  );
  import dram_bridge_pkg::*;

  logic     full_r;
  logic     load;
  mem_msg_e msg_type_r;
  paddr_t   addr_r;
  word_t    data_r;

  // room when empty, or when the entry leaves this cycle
  assign fwd_ready_o = !full_r || req_o.take;
  assign load        = fwd_v_i && fwd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      full_r <= 1'b0;
    else if (load)
      full_r <= 1'b1;
    else if (req_o.take)
      full_r <= 1'b0;
  end

  // payload only moves on a processor transfer
  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      msg_type_r <= fwd_msg_type_i;
      addr_r     <= fwd_addr_i;
      data_r     <= fwd_data_i;
    end
  end

  assign req_o.valid    = full_r;
  assign req_o.msg_type = msg_type_r;
  assign req_o.addr     = addr_r;
  assign req_o.data     = data_r;

endmodule

// ==== source/dram_addr_hash.sv ====
`timescale 1ns/100ps
`include "dram_bridge_defs.svh"

module dram_addr_hash
  (
    input  dram_bridge_pkg::paddr_t  addr_i,
    input  dram_bridge_pkg::paddr_t  dram_offset_i,
    output dram_bridge_pkg::x_cord_t x_o,
    output dram_bridge_pkg::y_cord_t y_o,
    output dram_bridge_pkg::epa_t    epa_o
  );
  import dram_bridge_pkg::*;

  // bit positions inside the word address
  localparam int ROW_BIT   = `DB_BLOCK_LOG + `DB_TILES_X_LOG;
  localparam int UPPER_LSB = ROW_BIT + 1;
  localparam int EPA_FULL  = `DB_PADDR_W - UPPER_LSB + `DB_BLOCK_LOG;

  paddr_t                      word_addr;
  logic [`DB_BLOCK_LOG-1:0]    block_off;
  logic [`DB_TILES_X_LOG-1:0]  tile_sel;
  logic [`DB_TILES_X_LOG-1:0]  tile_x;
  logic [EPA_FULL-1:0]         epa_full;

  // byte address to word address, then into the dram window
  assign word_addr = (addr_i >> 2) + dram_offset_i;
  assign block_off = word_addr[`DB_BLOCK_LOG-1:0];
  assign tile_sel  = word_addr[`DB_BLOCK_LOG +: `DB_TILES_X_LOG];

  // spread consecutive rows across the tiles
  if (`DB_HASH_XOR != 0)
  begin : g_xor_hash
    assign tile_x = tile_sel ^ word_addr[UPPER_LSB +: `DB_TILES_X_LOG];
  end
  else
  begin : g_plain_hash
    assign tile_x = tile_sel;
  end

  assign x_o = x_cord_t'(tile_x);
  assign y_o = word_addr[ROW_BIT] ? y_cord_t'(`DB_Y_SOUTH) : y_cord_t'(`DB_Y_NORTH);

  // tile drops the x and row bits, keeps block offset at the bottom
  assign epa_full = {word_addr[`DB_PADDR_W-1:UPPER_LSB], block_off};
  assign epa_o    = epa_full[`DB_EPA_W-1:0];

endmodule

// ==== source/request_issue.sv ====
`timescale 1ns/100ps

module request_issue
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    fwd_req_if.dst                   req_i,
    tag_alloc_if.user                alloc_o,
    input  dram_bridge_pkg::paddr_t  dram_offset_i,
    output logic                     net_v_o,
    input  logic                     net_ready_i,
    output dram_bridge_pkg::net_op_e net_op_o,
    output dram_bridge_pkg::x_cord_t net_x_o,
    output dram_bridge_pkg::y_cord_t net_y_o,
    output dram_bridge_pkg::epa_t    net_epa_o,
    output dram_bridge_pkg::word_t   net_data_o,
    output dram_bridge_pkg::tag_t    net_tag_o
  );
  import dram_bridge_pkg::*;

  x_cord_t hash_x;
  y_cord_t hash_y;
  epa_t    hash_epa;
  logic    space;
  logic    fire;

  // output packet register
  logic    pkt_v_r;
  net_op_e pkt_op_r;
  x_cord_t pkt_x_r;
  y_cord_t pkt_y_r;
  epa_t    pkt_epa_r;
  word_t   pkt_data_r;
  tag_t    pkt_tag_r;

  dram_addr_hash u_hash
  (
    .addr_i        (req_i.addr),
    .dram_offset_i (dram_offset_i),
    .x_o           (hash_x),
    .y_o           (hash_y),
    .epa_o         (hash_epa)
  );

  // --------------------
  // issue condition
  assign space = !pkt_v_r || net_ready_i;
  assign fire  = req_i.valid && alloc_o.avail && space;

  assign req_i.take       = fire;
  assign alloc_o.take     = fire;
  assign alloc_o.msg_type = req_i.msg_type;
  assign alloc_o.addr     = req_i.addr;

  // --------------------
  // packet register toward the network
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      pkt_v_r <= 1'b0;
    else if (fire)
      pkt_v_r <= 1'b1;
    else if (net_ready_i)
      pkt_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (fire)
    begin
      pkt_op_r   <= (req_i.msg_type == MSG_WR) ? OP_STORE : OP_LOAD;
      pkt_x_r    <= hash_x;
      pkt_y_r    <= hash_y;
      pkt_epa_r  <= hash_epa;
      pkt_data_r <= req_i.data;
      pkt_tag_r  <= alloc_o.tag;
    end
  end

  assign net_v_o    = pkt_v_r;
  assign net_op_o   = pkt_op_r;
  assign net_x_o    = pkt_x_r;
  assign net_y_o    = pkt_y_r;
  assign net_epa_o  = pkt_epa_r;
  assign net_data_o = pkt_data_r;
  assign net_tag_o  = pkt_tag_r;

endmodule

// ==== source/reorder_return.sv ====
`timescale 1ns/100ps
`include "dram_bridge_defs.svh"

module reorder_return
  (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    tag_alloc_if.owner                alloc_i,
    input  logic                      net_ret_v_i,
    input  dram_bridge_pkg::tag_t     net_ret_tag_i,
    input  dram_bridge_pkg::word_t    net_ret_data_i,
    output logic                      rev_v_o,
    input  logic                      rev_ready_i,
    output dram_bridge_pkg::mem_msg_e rev_msg_type_o,
    output dram_bridge_pkg::paddr_t   rev_addr_o,
    output dram_bridge_pkg::word_t    rev_data_o
  );
  import dram_bridge_pkg::*;

  localparam logic [`DB_TAG_W:0] FULL_COUNT = `DB_TAGS;

  tag_t                alloc_ptr_r;
  tag_t                head_ptr_r;
  logic [`DB_TAG_W:0]  count_r;
  logic [`DB_TAGS-1:0] filled_r;
  logic                retire;

  // per-entry storage
  mem_msg_e hdr_msg_q  [`DB_TAGS];
  paddr_t   hdr_addr_q [`DB_TAGS];
  word_t    data_q     [`DB_TAGS];

  assign alloc_i.avail = (count_r != FULL_COUNT);
  assign alloc_i.tag   = alloc_ptr_r;
  assign retire        = rev_v_o && rev_ready_i;

  // --------------------
  // pointers, occupancy, fill bits
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      alloc_ptr_r <= '0;
      head_ptr_r  <= '0;
      count_r     <= '0;
      filled_r    <= '0;
    end
    else
    begin
      if (alloc_i.take)
        alloc_ptr_r <= alloc_ptr_r + 1'b1;
      if (retire)
        head_ptr_r <= head_ptr_r + 1'b1;
      case ({alloc_i.take, retire})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
      // a return never targets the entry being retired
      if (net_ret_v_i)
        filled_r[net_ret_tag_i] <= 1'b1;
      if (retire)
        filled_r[head_ptr_r] <= 1'b0;
    end
  end

  // headers on allocation, data on return
  always_ff @(posedge clk_i)
  begin
    if (alloc_i.take)
    begin
      hdr_msg_q[alloc_ptr_r]  <= alloc_i.msg_type;
      hdr_addr_q[alloc_ptr_r] <= alloc_i.addr;
    end
    if (net_ret_v_i)
      data_q[net_ret_tag_i] <= net_ret_data_i;
  end

  // --------------------
  // in-order response from the head
  assign rev_v_o        = filled_r[head_ptr_r];
  assign rev_msg_type_o = hdr_msg_q[head_ptr_r];
  assign rev_addr_o     = hdr_addr_q[head_ptr_r];
  assign rev_data_o     = data_q[head_ptr_r];

endmodule

// ==== source/dram_bridge_top.sv ====
`timescale 1ns/100ps

module dram_bridge_top
  (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // processor request
    input  logic                      fwd_v_i,
    output logic                      fwd_ready_o,
    input  dram_bridge_pkg::mem_msg_e fwd_msg_type_i,
    input  dram_bridge_pkg::paddr_t   fwd_addr_i,
    input  dram_bridge_pkg::word_t    fwd_data_i,

    // processor response
    output logic                      rev_v_o,
    input  logic                      rev_ready_i,
    output dram_bridge_pkg::mem_msg_e rev_msg_type_o,
    output dram_bridge_pkg::paddr_t   rev_addr_o,
    output dram_bridge_pkg::word_t    rev_data_o,

    // network request packet
    output logic                      net_v_o,
    input  logic                      net_ready_i,
    output dram_bridge_pkg::net_op_e  net_op_o,
    output dram_bridge_pkg::x_cord_t  net_x_o,
    output dram_bridge_pkg::y_cord_t  net_y_o,
    output dram_bridge_pkg::epa_t     net_epa_o,
    output dram_bridge_pkg::word_t    net_data_o,
    output dram_bridge_pkg::tag_t     net_tag_o,

    // network return, always accepted
    input  logic                      net_ret_v_i,
    input  dram_bridge_pkg::tag_t     net_ret_tag_i,
    input  dram_bridge_pkg::word_t    net_ret_data_i,

    // base of the dram window, in words
    input  dram_bridge_pkg::paddr_t   dram_offset_i
  );

  fwd_req_if   u_fwd_req ();
  tag_alloc_if u_tag_alloc ();

  fwd_intake u_intake
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fwd_v_i        (fwd_v_i),
    .fwd_ready_o    (fwd_ready_o),
    .fwd_msg_type_i (fwd_msg_type_i),
    .fwd_addr_i     (fwd_addr_i),
    .fwd_data_i     (fwd_data_i),
    .req_o          (u_fwd_req.src)
  );

  request_issue u_issue
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (u_fwd_req.dst),
    .alloc_o       (u_tag_alloc.user),
    .dram_offset_i (dram_offset_i),
    .net_v_o       (net_v_o),
    .net_ready_i   (net_ready_i),
    .net_op_o      (net_op_o),
    .net_x_o       (net_x_o),
    .net_y_o       (net_y_o),
    .net_epa_o     (net_epa_o),
    .net_data_o    (net_data_o),
    .net_tag_o     (net_tag_o)
  );

  reorder_return u_reorder
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .alloc_i        (u_tag_alloc.owner),
    .net_ret_v_i    (net_ret_v_i),
    .net_ret_tag_i  (net_ret_tag_i),
    .net_ret_data_i (net_ret_data_i),
    .rev_v_o        (rev_v_o),
    .rev_ready_i    (rev_ready_i),
    .rev_msg_type_o (rev_msg_type_o),
    .rev_addr_o     (rev_addr_o),
    .rev_data_o     (rev_data_o)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen
  #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
  )
  (
    output logic clk_o,
    output logic rst_n_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge, away from the sampling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== verification/dram_bridge_assertions.sv ====
`timescale 1ns/100ps

module dram_bridge_assertions
  (
    input logic                      clk_i,
    input logic                      rst_n_i,
    input logic                      net_v_o,
    input logic                      net_ready_i,
    input dram_bridge_pkg::net_op_e  net_op_o,
    input dram_bridge_pkg::x_cord_t  net_x_o,
    input dram_bridge_pkg::y_cord_t  net_y_o,
    input dram_bridge_pkg::epa_t     net_epa_o,
    input dram_bridge_pkg::word_t    net_data_o,
    input dram_bridge_pkg::tag_t     net_tag_o,
    input logic                      rev_v_o,
    input logic                      rev_ready_i,
    input dram_bridge_pkg::mem_msg_e rev_msg_type_o,
    input dram_bridge_pkg::paddr_t   rev_addr_o,
    input dram_bridge_pkg::word_t    rev_data_o
  );

  int fail_count = 0;

  // --------------------
  // network packet holds while the network stalls
  property net_hold_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      (net_v_o && !net_ready_i) |=> (net_v_o && $stable(net_op_o) && $stable(net_x_o)
        && $stable(net_y_o) && $stable(net_epa_o) && $stable(net_data_o)
        && $stable(net_tag_o));
  endproperty

  // response holds while the processor stalls
  property rev_hold_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      (rev_v_o && !rev_ready_i) |=> (rev_v_o && $stable(rev_msg_type_o)
        && $stable(rev_addr_o) && $stable(rev_data_o));
  endproperty

  // both valid outputs stay low through reset
  property quiet_reset_p;
    @(posedge clk_i) (!rst_n_i) |=> (!net_v_o && !rev_v_o);
  endproperty

  a_net_hold : assert property (net_hold_p)
  else
  begin
    fail_count++;
    $error("net packet changed while net_ready_i was low");
  end

  a_rev_hold : assert property (rev_hold_p)
  else
  begin
    fail_count++;
    $error("rev response changed while rev_ready_i was low");
  end

  a_quiet_reset : assert property (quiet_reset_p)
  else
  begin
    fail_count++;
    $error("valid output raised during reset");
  end

endmodule

bind dram_bridge_top dram_bridge_assertions u_assertions (.*);

// ==== verification/dram_bridge_tb.sv ====
`timescale 1ns/100ps
`include "dram_bridge_defs.svh"

module dram_bridge_tb;
  import dram_bridge_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int SWEEP_N         = 12;
  localparam int TOTAL_REQS      = 2 + 3 * SWEEP_N + 8 + 12 + 8;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 30 + 1000;
  localparam int DRAIN_LIMIT     = 500;
  localparam int KEY_W           = `DB_X_W + `DB_Y_W + `DB_EPA_W;

  typedef logic [KEY_W-1:0] key_t;

  typedef struct packed
  {
    net_op_e op;
    x_cord_t x;
    y_cord_t y;
    epa_t    epa;
    word_t   data;
  } pkt_exp_t;

  typedef struct packed
  {
    mem_msg_e msg;
    paddr_t   addr;
    word_t    data;
  } rsp_exp_t;

  typedef struct packed
  {
    tag_t  tag;
    word_t data;
  } ret_entry_t;

  logic     clk;
  logic     rst_n;
  logic     fwd_v_i;
  logic     fwd_ready_o;
  mem_msg_e fwd_msg_type_i;
  paddr_t   fwd_addr_i;
  word_t    fwd_data_i;
  logic     rev_v_o;
  logic     rev_ready_i;
  mem_msg_e rev_msg_type_o;
  paddr_t   rev_addr_o;
  word_t    rev_data_o;
  logic     net_v_o;
  logic     net_ready_i;
  net_op_e  net_op_o;
  x_cord_t  net_x_o;
  y_cord_t  net_y_o;
  epa_t     net_epa_o;
  word_t    net_data_o;
  tag_t     net_tag_o;
  logic     net_ret_v_i;
  tag_t     net_ret_tag_i;
  word_t    net_ret_data_i;
  paddr_t   dram_offset_i;

  // test controls for the network and processor models
  logic rev_stall = 1'b0;
  logic net_stall = 1'b0;
  logic ret_hold  = 1'b0;

  logic [31:0] lfsr_q = 32'h5b45_5556;
  int          err_count    = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;

  pkt_exp_t   exp_pkt[$];
  rsp_exp_t   exp_rsp[$];
  ret_entry_t pending[$];
  word_t      net_mem [key_t];
  word_t      exp_mem [key_t];

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) u_clk_gen
  (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dram_bridge_top u_dut
  (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .*
  );

  // --------------------
  // random source with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // unwritten dram words read back as their own location
  function automatic word_t fill_word(input key_t key);
    return word_t'({8'hd0, key});
  endfunction

  // tile and epa from the block and row split of the word address
  function automatic void ref_hash(input paddr_t addr, input paddr_t offset,
                                   output x_cord_t x, output y_cord_t y, output epa_t epa);
    int unsigned blk_words;
    int unsigned tiles;
    int unsigned w;
    int unsigned tile;
    int unsigned upper;
    blk_words = 1 << `DB_BLOCK_LOG;
    tiles     = 1 << `DB_TILES_X_LOG;
    w         = (addr / 4 + offset) % (1 << `DB_PADDR_W);
    tile      = (w / blk_words) % tiles;
    upper     = w / (blk_words * tiles * 2);
    if (`DB_HASH_XOR != 0)
      tile = tile ^ (upper % tiles);
    x   = x_cord_t'(tile);
    y   = ((w / (blk_words * tiles)) % 2 == 1) ? y_cord_t'(`DB_Y_SOUTH) : y_cord_t'(`DB_Y_NORTH);
    epa = epa_t'(upper * blk_words + w % blk_words);
  endfunction

  // --------------------
  // compare tasks
  task automatic log_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    err_count++;
    $display("ERR %s: got %h expected %h", sig, got, exp);
  endtask

  task automatic log_failure(input string what);
    err_count++;
    $display("%s", what);
  endtask

  task automatic check_word(input string sig, input word_t got, input word_t exp);
    if (got !== exp)
      log_mismatch(sig, got, exp);
  endtask

  task automatic check_addr(input string sig, input paddr_t got, input paddr_t exp);
    if (got !== exp)
      log_mismatch(sig, 32'(got), 32'(exp));
  endtask

  task automatic check_msg(input string sig, input mem_msg_e got, input mem_msg_e exp);
    if (got !== exp)
      log_mismatch(sig, 32'(got), 32'(exp));
  endtask

  task automatic check_op(input string sig, input net_op_e got, input net_op_e exp);
    if (got !== exp)
      log_mismatch(sig, 32'(got), 32'(exp));
  endtask

  task automatic check_x(input string sig, input x_cord_t got, input x_cord_t exp);
    if (got !== exp)
      log_mismatch(sig, 32'(got), 32'(exp));
  endtask

  task automatic check_y(input string sig, input y_cord_t got, input y_cord_t exp);
    if (got !== exp)
      log_mismatch(sig, 32'(got), 32'(exp));
  endtask

  task automatic check_epa(input string sig, input epa_t got, input epa_t exp);
    if (got !== exp)
      log_mismatch(sig, 32'(got), 32'(exp));
  endtask

  task automatic check_tag(input string sig, input tag_t got, input tag_t exp);
    if (got !== exp)
      log_mismatch(sig, 32'(got), 32'(exp));
  endtask

  task automatic check_flag(input string sig, input logic got, input logic exp);
    if (got !== exp)
      log_mismatch(sig, 32'(got), 32'(exp));
  endtask

  // --------------------
  // network responder with tile access in arrival order
  initial
  begin
    ret_entry_t ent;
    pkt_exp_t   e;
    key_t       key;
    int         idx;
    int         pkt_count;
    pkt_count      = 0;
    net_ready_i    = 1'b1;
    net_ret_v_i    = 1'b0;
    net_ret_tag_i  = '0;
    net_ret_data_i = '0;
    forever
    begin
      @(negedge clk);
      net_ready_i = !net_stall;
      net_ret_v_i = 1'b0;
      if (pending.size() > 0 && !ret_hold && rand_bits(1))
      begin
        idx            = rand_bits(3) % pending.size();
        net_ret_v_i    = 1'b1;
        net_ret_tag_i  = pending[idx].tag;
        net_ret_data_i = pending[idx].data;
        pending.delete(idx);
      end
      // transfer happens at the coming rising edge
      if (net_v_o && net_ready_i)
      begin
        if (exp_pkt.size() == 0)
          log_failure("packet on the network port with no request outstanding");
        else
        begin
          e = exp_pkt.pop_front();
          check_op("net_op_o", net_op_o, e.op);
          check_x("net_x_o", net_x_o, e.x);
          check_y("net_y_o", net_y_o, e.y);
          check_epa("net_epa_o", net_epa_o, e.epa);
          check_word("net_data_o", net_data_o, e.data);
          // ids circle from zero in packet order since reset
          check_tag("net_tag_o", net_tag_o, tag_t'(pkt_count % `DB_TAGS));
        end
        key     = {net_x_o, net_y_o, net_epa_o};
        ent.tag = net_tag_o;
        if (net_op_o == OP_STORE)
        begin
          net_mem[key] = net_data_o;
          ent.data     = '0;
        end
        else
          ent.data = net_mem.exists(key) ? net_mem[key] : fill_word(key);
        pending.push_back(ent);
        pkt_count++;
      end
    end
  end

  // processor response side
  initial
  begin
    rsp_exp_t e;
    rev_ready_i = 1'b1;
    forever
    begin
      @(negedge clk);
      rev_ready_i = !rev_stall;
      if (rev_v_o && rev_ready_i)
      begin
        if (exp_rsp.size() == 0)
          log_failure("response on rev with no request outstanding");
        else
        begin
          e = exp_rsp.pop_front();
          check_msg("rev_msg_type_o", rev_msg_type_o, e.msg);
          check_addr("rev_addr_o", rev_addr_o, e.addr);
          check_word("rev_data_o", rev_data_o, e.data);
        end
      end
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  // --------------------
  // request driver and helpers
  task automatic send_req(input mem_msg_e msg, input paddr_t addr, input word_t data);
    x_cord_t  x;
    y_cord_t  y;
    epa_t     epa;
    key_t     key;
    pkt_exp_t pkt;
    rsp_exp_t rsp;
    ref_hash(addr, dram_offset_i, x, y, epa);
    key      = {x, y, epa};
    pkt.op   = (msg == MSG_WR) ? OP_STORE : OP_LOAD;
    pkt.x    = x;
    pkt.y    = y;
    pkt.epa  = epa;
    pkt.data = data;
    rsp.msg  = msg;
    rsp.addr = addr;
    rsp.data = '0;
    if (msg == MSG_WR)
      exp_mem[key] = data;
    else
      rsp.data = exp_mem.exists(key) ? exp_mem[key] : fill_word(key);
    exp_pkt.push_back(pkt);
    exp_rsp.push_back(rsp);
    @(negedge clk);
    fwd_v_i        = 1'b1;
    fwd_msg_type_i = msg;
    fwd_addr_i     = addr;
    fwd_data_i     = data;
    #(CLK_PERIOD / 4);
    while (!fwd_ready_o)
    begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
    end
    @(negedge clk);
    fwd_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_rsp.size() != 0 || exp_pkt.size() != 0 || pending.size() != 0)
           && cycles < DRAIN_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= DRAIN_LIMIT)
      log_failure($sformatf("drain timed out, %0d responses missing", exp_rsp.size()));
    repeat (3) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int start);
    tests_run++;
    if (err_count == start)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - start);
    end
  endtask

  // --------------------
  // directed tests
  task automatic test_reset();
    int start;
    start = err_count;
    check_flag("fwd_ready_o", fwd_ready_o, 1'b1);
    check_flag("net_v_o", net_v_o, 1'b0);
    check_flag("rev_v_o", rev_v_o, 1'b0);
    report_test("reset", start);
  endtask

  task automatic test_write_read();
    int start;
    start = err_count;
    send_req(MSG_WR, 28'h000_0148, 32'hcafe_0123);
    send_req(MSG_RD, 28'h000_0148, '0);
    wait_drain();
    report_test("write_read", start);
  endtask

  // writes, reads back, then reads through a shifted window
  task automatic test_sweep();
    int     start;
    paddr_t addr;
    start = err_count;
    for (int pass = 0; pass < 3; pass++)
    begin
      if (pass == 2)
        dram_offset_i = 28'h001_2345;
      for (int i = 0; i < SWEEP_N; i++)
      begin
        addr = paddr_t'(i * 'h64);
        if (pass == 0)
          send_req(MSG_WR, addr, rand_bits(32));
        else
          send_req(MSG_RD, addr, '0);
      end
      wait_drain();
    end
    dram_offset_i = '0;
    report_test("sweep", start);
  endtask

  task automatic test_reorder();
    int start;
    int cycles;
    start    = err_count;
    ret_hold = 1'b1;
    for (int i = 0; i < 8; i++)
      send_req(MSG_RD, paddr_t'(28'h040_0000 + i * 'h8c), '0);
    cycles = 0;
    while (pending.size() < 8 && cycles < 200)
    begin
      @(negedge clk);
      cycles++;
    end
    if (pending.size() < 8)
      log_failure("eight reads never all reached the network");
    ret_hold = 1'b0;
    wait_drain();
    report_test("reorder", start);
  endtask

  task automatic test_rev_stall();
    int   start;
    int   cycles;
    logic seen;
    start     = err_count;
    rev_stall = 1'b1;
    fork
      for (int i = 0; i < 12; i++)
        send_req((i % 2 == 1) ? MSG_RD : MSG_WR, paddr_t'(28'h010_0000 + (i / 2) * 'h2c0),
                 rand_bits(32));
    join_none
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < 300)
    begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      seen = fwd_v_i && !fwd_ready_o;
      cycles++;
    end
    if (!seen)
      log_failure("fwd_ready_o never fell with all tags in use");
    @(negedge clk);
    rev_stall = 1'b0;
    wait fork;
    wait_drain();
    report_test("rev_stall", start);
  endtask

  task automatic test_net_stall();
    int start;
    start     = err_count;
    net_stall = 1'b1;
    fork
      for (int i = 0; i < 8; i++)
        send_req((i < 4) ? MSG_WR : MSG_RD, paddr_t'(28'h020_0000 + (i % 4) * 'h1a4),
                 rand_bits(32));
    join_none
    repeat (20) @(negedge clk);
    net_stall = 1'b0;
    wait fork;
    wait_drain();
    report_test("net_stall", start);
  endtask

  // --------------------
  initial
  begin
    int total_errs;
    fwd_v_i        = 1'b0;
    fwd_msg_type_i = MSG_RD;
    fwd_addr_i     = '0;
    fwd_data_i     = '0;
    dram_offset_i  = '0;
    @(posedge rst_n);
    @(negedge clk);
    test_reset();
    test_write_read();
    test_sweep();
    test_reorder();
    test_rev_stall();
    test_net_stall();
    total_errs = err_count + u_dut.u_assertions.fail_count;
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+source
source/dram_bridge_pkg.sv
source/dram_bridge_if.sv
source/fwd_intake.sv
source/dram_addr_hash.sv
source/request_issue.sv
source/reorder_return.sv
source/dram_bridge_top.sv
verification/tb_clock_gen.sv
verification/dram_bridge_assertions.sv
verification/dram_bridge_tb.sv
